//--- verilog/sine_quarter_table.svh
`ifndef SINE_QUARTER_TABLE_SVH
`define SINE_QUARTER_TABLE_SVH

// first quarter of the sine, sampled at half-step offsets
// so the folded quadrants mirror without a repeated point
5'd0:  quarter_mag = 11'd50;
5'd1:  quarter_mag = 11'd151;
5'd2:  quarter_mag = 11'd251;
5'd3:  quarter_mag = 11'd350;
5'd4:  quarter_mag = 11'd448;
5'd5:  quarter_mag = 11'd546;
5'd6:  quarter_mag = 11'd642;
5'd7:  quarter_mag = 11'd737;
5'd8:  quarter_mag = 11'd830;
5'd9:  quarter_mag = 11'd920;
5'd10: quarter_mag = 11'd1009;
5'd11: quarter_mag = 11'd1095;
5'd12: quarter_mag = 11'd1179;
5'd13: quarter_mag = 11'd1259;
5'd14: quarter_mag = 11'd1337;
5'd15: quarter_mag = 11'd1411;
5'd16: quarter_mag = 11'd1483;
5'd17: quarter_mag = 11'd1550;
5'd18: quarter_mag = 11'd1614;
5'd19: quarter_mag = 11'd1674;
5'd20: quarter_mag = 11'd1729;
5'd21: quarter_mag = 11'd1781;
5'd22: quarter_mag = 11'd1828;
5'd23: quarter_mag = 11'd1871;
5'd24: quarter_mag = 11'd1910;
5'd25: quarter_mag = 11'd1944;
5'd26: quarter_mag = 11'd1973;
5'd27: quarter_mag = 11'd1997;
5'd28: quarter_mag = 11'd2017;
5'd29: quarter_mag = 11'd2032;
5'd30: quarter_mag = 11'd2041;
5'd31: quarter_mag = 11'd2046;   // peak stays just under full scale

`endif

//--- verilog/dds_lab_pkg.sv
package dds_lab_pkg;

   //////////////////////////////
   // widths
   //////////////////////////////
   localparam int SAMPLE_W = 12;                 // waveform sample
   localparam int PHASE_W  = 32;                 // nco accumulator
   localparam int LFSR_W   = 5;
   localparam int SCOPE_W  = 8;                  // one plotted trace

   typedef logic signed [SAMPLE_W-1:0] sample_t;

   localparam sample_t SAMPLE_MAX = 12'sh7ff;    // +2047
   localparam sample_t SAMPLE_MIN = 12'sh800;    // -2048

   //////////////////////////////
   // keyboard events
   //////////////////////////////
   // one decoded event byte, bit 7 marks a break
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic       brk;
         logic [6:0] code;
      } fields;
   } key_event_u;

   localparam logic [6:0] KEY_1     = 7'h16;
   localparam logic [6:0] KEY_2     = 7'h1e;
   localparam logic [6:0] KEY_3     = 7'h26;
   localparam logic [6:0] KEY_4     = 7'h25;
   localparam logic [6:0] KEY_5     = 7'h2e;
   localparam logic [6:0] KEY_6     = 7'h36;
   localparam logic [6:0] KEY_7     = 7'h3d;
   localparam logic [6:0] KEY_8     = 7'h3e;
   localparam logic [6:0] KEY_F1    = 7'h05;
   localparam logic [6:0] KEY_F2    = 7'h06;
   localparam logic [6:0] KEY_N     = 7'h31;
   localparam logic [6:0] KEY_M     = 7'h3a;
   localparam logic [6:0] KEY_SPACE = 7'h29;
   localparam logic [6:0] KEY_LEFT  = 7'h6b;
   localparam logic [6:0] KEY_RIGHT = 7'h74;
   localparam logic [6:0] KEY_UP    = 7'h75;
   localparam logic [6:0] KEY_DOWN  = 7'h72;

   typedef struct packed {
      logic [7:0] num;                           // bit 0 is key 1
      logic       f1;
      logic       f2;
      logic       n;
      logic       m;
      logic       space;
      logic       left;
      logic       right;
      logic       up;
      logic       down;
   } held_keys_t;

   //////////////////////////////
   // selections and samples
   //////////////////////////////
   typedef enum logic [1:0] {WAVE_SIN, WAVE_COS, WAVE_SQUARE, WAVE_SAW} wave_sel_e;
   typedef enum logic [1:0] {MOD_OOK, MOD_SQUARE, MOD_NONE, MOD_PRBS} mod_sel_e;

   typedef struct packed {
      sample_t sin;
      sample_t cos;
      sample_t squ;
      sample_t saw;
   } waves_t;

   typedef struct packed {
      logic [SCOPE_W-1:0] sig_trace;
      logic [SCOPE_W-1:0] mod_trace;
   } scope_samples_t;

endpackage

//--- verilog/keypad_control.sv
`timescale 1ns/1ps

module keypad_control (
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  logic                    key_event_valid,
   input  dds_lab_pkg::key_event_u key_event,
   output dds_lab_pkg::held_keys_t held_keys,
   output dds_lab_pkg::wave_sel_e  wave_sel,
   output dds_lab_pkg::mod_sel_e   mod_sel
);

   logic       make;                               // 0 on a break event
   logic       num_hit;
   logic [2:0] num_idx;                            // key 1 maps to 0

   assign make = ~key_event.fields.brk;

   //////////////////////////////
   // number key decode
   //////////////////////////////
   always_comb
   begin
      num_hit = 1'b1;
      num_idx = 3'd0;
      case (key_event.fields.code)
         dds_lab_pkg::KEY_1: num_idx = 3'd0;
         dds_lab_pkg::KEY_2: num_idx = 3'd1;
         dds_lab_pkg::KEY_3: num_idx = 3'd2;
         dds_lab_pkg::KEY_4: num_idx = 3'd3;
         dds_lab_pkg::KEY_5: num_idx = 3'd4;
         dds_lab_pkg::KEY_6: num_idx = 3'd5;
         dds_lab_pkg::KEY_7: num_idx = 3'd6;
         dds_lab_pkg::KEY_8: num_idx = 3'd7;
         default:            num_hit = 1'b0;
      endcase
   end

   //////////////////////////////
   // held levels and selections
   //////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_keys <= '0;
         wave_sel  <= dds_lab_pkg::WAVE_SIN;
         mod_sel   <= dds_lab_pkg::MOD_OOK;
      end
      else if (key_event_valid)
      begin
         if (num_hit)
         begin
            held_keys.num[num_idx] <= make;
            // keys 1-4 pick the wave, 5-8 the modulation
            if (make && !num_idx[2])
               wave_sel <= dds_lab_pkg::wave_sel_e'(num_idx[1:0]);
            else if (make)
               mod_sel <= dds_lab_pkg::mod_sel_e'(num_idx[1:0]);
         end
         case (key_event.fields.code)
            dds_lab_pkg::KEY_F1:    held_keys.f1    <= make;
            dds_lab_pkg::KEY_F2:    held_keys.f2    <= make;
            dds_lab_pkg::KEY_N:     held_keys.n     <= make;
            dds_lab_pkg::KEY_M:     held_keys.m     <= make;
            dds_lab_pkg::KEY_SPACE: held_keys.space <= make;
            dds_lab_pkg::KEY_LEFT:  held_keys.left  <= make;
            dds_lab_pkg::KEY_RIGHT: held_keys.right <= make;
            dds_lab_pkg::KEY_UP:    held_keys.up    <= make;
            dds_lab_pkg::KEY_DOWN:  held_keys.down  <= make;
            default:                ;               // unlisted codes ignored
         endcase
      end
   end

endmodule

//--- verilog/prbs_source.sv
`timescale 1ns/1ps

module prbs_source #(
   parameter int TICK_DIVIDE = 16
) (
   input  logic                           CLK_25MHZ,
   input  logic                           reset_from_key,
   output logic [dds_lab_pkg::LFSR_W-1:0] lfsr_state
);

   localparam int CNT_W = ($clog2(TICK_DIVIDE) > 0) ? $clog2(TICK_DIVIDE) : 1;

   logic [CNT_W-1:0] tick_cnt;
   logic             step_tick;                    // one cycle per lfsr step
   logic             feedback;

   assign step_tick = (tick_cnt == CNT_W'(TICK_DIVIDE - 1));

   // taps at bits 4 and 2 give the full 31-state cycle
   assign feedback = lfsr_state[dds_lab_pkg::LFSR_W-1] ^ lfsr_state[dds_lab_pkg::LFSR_W-3];

   //////////////////////////////
   // slow tick and lfsr
   //////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         tick_cnt   <= '0;
         lfsr_state <= dds_lab_pkg::LFSR_W'(1);      // any nonzero seed
      end
      else if (step_tick)
      begin
         tick_cnt   <= '0;
         lfsr_state <= {lfsr_state[dds_lab_pkg::LFSR_W-2:0], feedback};
      end
      else
      begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

endmodule

//--- verilog/dds_waveform_gen.sv
`timescale 1ns/1ps

module dds_waveform_gen #(
   parameter logic [dds_lab_pkg::PHASE_W-1:0] PHASE_INC = 32'd172
) (
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   output dds_lab_pkg::waves_t waves
);

   localparam int ANGLE_W = 7;                     // quadrant plus table index

   logic [dds_lab_pkg::PHASE_W-1:0] phase;
   logic [ANGLE_W-1:0]              sin_angle;
   logic [ANGLE_W-1:0]              cos_angle;

   // fold one of four quadrants onto the quarter table
   function automatic dds_lab_pkg::sample_t fold_sine(input logic [ANGLE_W-1:0] angle);
      logic [4:0]  idx;
      logic [10:0] quarter_mag;
      logic [11:0] mag;
      idx = angle[5] ? ~angle[4:0] : angle[4:0];   // falling quarters mirror
      quarter_mag = 11'd0;
      case (idx)
`include "sine_quarter_table.svh"
      endcase
      mag = {1'b0, quarter_mag};
      fold_sine = angle[6] ? -mag : mag;           // lower half negated
   endfunction

   assign sin_angle = phase[dds_lab_pkg::PHASE_W-1 -: ANGLE_W];
   assign cos_angle = sin_angle + 7'd32;           // quarter turn ahead

   //////////////////////////////
   // phase accumulator
   //////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase <= '0;
      else
         phase <= phase + PHASE_INC;               // wraps once per period
   end

   //////////////////////////////
   // registered outputs
   //////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         waves <= '0;
      end
      else
      begin
         waves.sin <= fold_sine(sin_angle);
         waves.cos <= fold_sine(cos_angle);
         waves.squ <= phase[dds_lab_pkg::PHASE_W-1] ? dds_lab_pkg::SAMPLE_MIN
                                                     : dds_lab_pkg::SAMPLE_MAX;
         waves.saw <= phase[dds_lab_pkg::PHASE_W-1 -: dds_lab_pkg::SAMPLE_W];
      end
   end

endmodule

//--- verilog/modulation_mux.sv
`timescale 1ns/1ps

module modulation_mux (
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  dds_lab_pkg::waves_t    waves,
   input  dds_lab_pkg::wave_sel_e wave_sel,
   input  dds_lab_pkg::mod_sel_e  mod_sel,
   input  logic                   prbs_bit,
   output dds_lab_pkg::sample_t   sig_sample,
   output dds_lab_pkg::sample_t   mod_sample
);

   dds_lab_pkg::sample_t sig_next;
   dds_lab_pkg::sample_t mod_next;

   //////////////////////////////
   // selection
   //////////////////////////////
   always_comb
   begin
      case (wave_sel)
         dds_lab_pkg::WAVE_SIN:    sig_next = waves.sin;
         dds_lab_pkg::WAVE_COS:    sig_next = waves.cos;
         dds_lab_pkg::WAVE_SQUARE: sig_next = waves.squ;
         default:                  sig_next = waves.saw;
      endcase
   end

   always_comb
   begin
      case (mod_sel)
         dds_lab_pkg::MOD_OOK:    mod_next = prbs_bit ? '0 : waves.sin;   // carrier keyed off
         dds_lab_pkg::MOD_SQUARE: mod_next = waves.squ;
         dds_lab_pkg::MOD_NONE:   mod_next = '0;   // nothing on this code
         default:                 mod_next = prbs_bit ? dds_lab_pkg::SAMPLE_MAX
                                                      : dds_lab_pkg::SAMPLE_MIN;
      endcase
   end

   // both outputs leave together so the traces stay aligned
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sig_sample <= '0;
         mod_sample <= '0;
      end
      else
      begin
         sig_sample <= sig_next;
         mod_sample <= mod_next;
      end
   end

endmodule

//--- verilog/scope_sampler.sv
`timescale 1ns/1ps

module scope_sampler #(
   parameter int SCOPE_DIVIDE = 70_000
) (
   input  logic                        CLK_25MHZ,
   input  logic                        reset_from_key,
   input  dds_lab_pkg::sample_t        sig_sample,
   input  dds_lab_pkg::sample_t        mod_sample,
   output logic                        scope_strobe,
   output dds_lab_pkg::scope_samples_t scope
);

   localparam int CNT_W = ($clog2(SCOPE_DIVIDE) > 0) ? $clog2(SCOPE_DIVIDE) : 1;

   logic [CNT_W-1:0] div_cnt;
   logic             capture;

   // flip the sign bit and keep the top bits for the plot
   function automatic logic [dds_lab_pkg::SCOPE_W-1:0] to_offset(
      input dds_lab_pkg::sample_t s
   );
      to_offset = {~s[dds_lab_pkg::SAMPLE_W-1], s[dds_lab_pkg::SAMPLE_W-2 -: 7]};
   endfunction

   assign capture = (div_cnt == CNT_W'(SCOPE_DIVIDE - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         div_cnt      <= '0;
         scope_strobe <= 1'b0;
      end
      else
      begin
         div_cnt      <= capture ? '0 : div_cnt + 1'b1;
         scope_strobe <= capture;                  // high with the fresh traces
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (capture)
      begin
         scope.sig_trace <= to_offset(sig_sample);
         scope.mod_trace <= to_offset(mod_sample);
      end
   end

endmodule

//--- verilog/dds_lab_top.sv
`timescale 1ns/1ps

module dds_lab_top #(
   parameter logic [dds_lab_pkg::PHASE_W-1:0] PHASE_INC = 32'd172,   // about 1 kHz
   parameter int TICK_DIVIDE  = 25_000_000,                         // lfsr steps at 1 Hz
   parameter int SCOPE_DIVIDE = 70_000
) (
   input  logic                           CLK_25MHZ,
   input  logic                           reset_from_key,
   input  logic                           key_event_valid,
   input  dds_lab_pkg::key_event_u        key_event,
   output dds_lab_pkg::held_keys_t        held_keys,
   output dds_lab_pkg::wave_sel_e         wave_sel,
   output dds_lab_pkg::mod_sel_e          mod_sel,
   output logic [dds_lab_pkg::LFSR_W-1:0] lfsr_state,
   output dds_lab_pkg::sample_t           sig_sample,
   output dds_lab_pkg::sample_t           mod_sample,
   output logic                           scope_strobe,
   output dds_lab_pkg::scope_samples_t    scope
);

   dds_lab_pkg::waves_t waves;

   //////////////////////////////
   // control
   //////////////////////////////
   keypad_control i_keypad_control (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_valid (key_event_valid),
      .key_event       (key_event),
      .held_keys       (held_keys),
      .wave_sel        (wave_sel),
      .mod_sel         (mod_sel)
   );

   //////////////////////////////
   // sources
   //////////////////////////////
   prbs_source #(.TICK_DIVIDE(TICK_DIVIDE)) i_prbs_source (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_state     (lfsr_state)
   );

   dds_waveform_gen #(.PHASE_INC(PHASE_INC)) i_dds_waveform_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .waves          (waves)
   );

   //////////////////////////////
   // selection and scope
   //////////////////////////////
   modulation_mux i_modulation_mux (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .waves          (waves),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .prbs_bit       (lfsr_state[0]),             // keying bit
      .sig_sample     (sig_sample),
      .mod_sample     (mod_sample)
   );

   scope_sampler #(.SCOPE_DIVIDE(SCOPE_DIVIDE)) i_scope_sampler (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sig_sample     (sig_sample),
      .mod_sample     (mod_sample),
      .scope_strobe   (scope_strobe),
      .scope          (scope)
   );

endmodule

//--- test/tb_dds_lab.sv
`timescale 1ns/1ps

module tb_dds_lab;

   localparam logic [31:0] PHASE_INC = 32'h0100_0000;   // 2^24 per cycle
   localparam int TICK_DIVIDE  = 16;
   localparam int SCOPE_DIVIDE = 10;
   localparam int NUM_KEYS     = 17;
   localparam int SINE_PEAK    = 2046;                  // largest quarter table entry
   localparam dds_lab_pkg::sample_t SQ_HIGH = 12'sd2047;
   localparam dds_lab_pkg::sample_t SQ_LOW  = -12'sd2048;
   // phase increment as seen in the top 12 phase bits
   localparam dds_lab_pkg::sample_t SAW_STEP = 12'(PHASE_INC >> 20);

   // listed keys in model order with number keys first
   localparam logic [6:0] KEY_CODES [NUM_KEYS] = '{
      dds_lab_pkg::KEY_1, dds_lab_pkg::KEY_2, dds_lab_pkg::KEY_3, dds_lab_pkg::KEY_4,
      dds_lab_pkg::KEY_5, dds_lab_pkg::KEY_6, dds_lab_pkg::KEY_7, dds_lab_pkg::KEY_8,
      dds_lab_pkg::KEY_F1, dds_lab_pkg::KEY_F2, dds_lab_pkg::KEY_N, dds_lab_pkg::KEY_M,
      dds_lab_pkg::KEY_SPACE, dds_lab_pkg::KEY_LEFT, dds_lab_pkg::KEY_RIGHT,
      dds_lab_pkg::KEY_UP, dds_lab_pkg::KEY_DOWN
   };

   logic                           CLK_25MHZ;
   logic                           reset_from_key;
   logic                           key_event_valid;
   dds_lab_pkg::key_event_u        key_event;
   dds_lab_pkg::held_keys_t        held_keys;
   dds_lab_pkg::wave_sel_e         wave_sel;
   dds_lab_pkg::mod_sel_e          mod_sel;
   logic [dds_lab_pkg::LFSR_W-1:0] lfsr_state;
   dds_lab_pkg::sample_t           sig_sample;
   dds_lab_pkg::sample_t           mod_sample;
   logic                           scope_strobe;
   dds_lab_pkg::scope_samples_t    scope;

   int          error_count;
   int          check_count;
   logic        timed_out;
   logic [31:0] rand_state;
   logic [16:0] model_keys;                             // same layout as held_keys
   dds_lab_pkg::wave_sel_e model_wave;
   dds_lab_pkg::mod_sel_e  model_mod;

   // monitor history kept per rising edge
   int                     settle;
   int                     since_strobe;
   logic                   strobe_seen;
   logic [4:0]             prev_lfsr;
   dds_lab_pkg::wave_sel_e prev_wave_sel;
   dds_lab_pkg::mod_sel_e  prev_mod_sel;
   dds_lab_pkg::wave_sel_e cur_kind;                    // wave held in sig_sample now
   dds_lab_pkg::wave_sel_e prev_kind;
   dds_lab_pkg::sample_t   prev_sig;
   dds_lab_pkg::sample_t   prev_mod;

   dds_lab_top #(
      .PHASE_INC    (PHASE_INC),
      .TICK_DIVIDE  (TICK_DIVIDE),
      .SCOPE_DIVIDE (SCOPE_DIVIDE)
   ) i_dds_lab_top (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_valid (key_event_valid),
      .key_event       (key_event),
      .held_keys       (held_keys),
      .wave_sel        (wave_sel),
      .mod_sel         (mod_sel),
      .lfsr_state      (lfsr_state),
      .sig_sample      (sig_sample),
      .mod_sample      (mod_sample),
      .scope_strobe    (scope_strobe),
      .scope           (scope)
   );

   always #20 CLK_25MHZ = ~CLK_25MHZ;                   // 25 MHz

   //////////////////////////////
   // helpers
   //////////////////////////////
   task automatic expect_equal(input string name, input logic [31:0] got,
                               input logic [31:0] want);
      check_count++;
      assert (got === want)
      else
      begin
         error_count++;
         $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      check_count++;
      assert (cond)
      else
      begin
         error_count++;
         $display("ERROR at %0t ns: %s", $time, what);
      end
   endtask

   task automatic end_run();
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   endtask

   function automatic logic [31:0] lfsr32_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // taps 32 22 2 1
   endfunction

   task automatic random_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++)
      begin
         rand_state = lfsr32_step(rand_state);
         value = (value << 1) | int'(rand_state[0]);
      end
   endtask

   function automatic logic [4:0] prbs_step(input logic [4:0] s);
      return {s[3:0], s[4] ^ s[2]};
   endfunction

   function automatic logic [7:0] offset_binary(input dds_lab_pkg::sample_t s);
      return 8'((int'(s) + 2048) >> 4);                 // bias to unsigned and keep top 8
   endfunction

   function automatic int model_pos(input int idx);
      return (idx < 8) ? 9 + idx : 16 - idx;            // num sits above f1..down
   endfunction

   function automatic int code_index(input logic [6:0] code);
      for (int i = 0; i < NUM_KEYS; i++)
         if (KEY_CODES[i] == code)
            return i;
      return -1;                                        // not a listed key
   endfunction

   // call right after a falling edge
   task automatic send_event(input logic brk, input logic [6:0] code);
      int idx;
      idx = code_index(code);
      key_event.raw   = {brk, code};
      key_event_valid = 1'b1;
      @(negedge CLK_25MHZ);
      key_event_valid = 1'b0;
      if (idx >= 0)
      begin
         model_keys[model_pos(idx)] = ~brk;
         if (!brk && idx < 4)
            model_wave = dds_lab_pkg::wave_sel_e'(2'(idx));
         else if (!brk && idx < 8)
            model_mod = dds_lab_pkg::mod_sel_e'(2'(idx - 4));
      end
      expect_equal("held_keys", 32'(held_keys), 32'(model_keys));
      expect_equal("wave_sel", 32'(wave_sel), 32'(model_wave));
      expect_equal("mod_sel", 32'(mod_sel), 32'(model_mod));
   endtask

   task automatic press_key(input int idx);
      send_event(1'b0, KEY_CODES[idx]);
      send_event(1'b1, KEY_CODES[idx]);
   endtask

   task automatic wait_strobes(input int count);
      int seen;
      int cycles;
      seen   = 0;
      cycles = 0;
      while (seen < count && cycles < count * SCOPE_DIVIDE * 4)
      begin
         @(negedge CLK_25MHZ);
         cycles++;
         if (scope_strobe)
            seen++;
      end
      if (seen < count)
      begin
         error_count++;
         timed_out = 1'b1;
         $display("timeout: only %0d of %0d scope strobes arrived", seen, count);
      end
   endtask

   task automatic wait_lfsr_steps(input int count);
      int         seen;
      int         cycles;
      logic [4:0] last;
      seen   = 0;
      cycles = 0;
      last   = lfsr_state;
      while (seen < count && cycles < count * TICK_DIVIDE * 4)
      begin
         @(negedge CLK_25MHZ);
         cycles++;
         if (lfsr_state != last)
            seen++;
         last = lfsr_state;
      end
      if (seen < count)
      begin
         error_count++;
         timed_out = 1'b1;
         $display("timeout: lfsr_state stepped only %0d of %0d times", seen, count);
      end
   endtask

   //////////////////////////////
   // per-cycle checks
   //////////////////////////////
   task automatic check_cycle();
      dds_lab_pkg::sample_t want;
      int                   s;
      s = int'(sig_sample);
      expect_true(lfsr_state != 5'd0, "lfsr_state reached zero");
      if (lfsr_state != prev_lfsr)
         expect_equal("lfsr_state", 32'(lfsr_state), 32'(prbs_step(prev_lfsr)));
      case (cur_kind)
         dds_lab_pkg::WAVE_SAW:
            if (prev_kind == dds_lab_pkg::WAVE_SAW)
            begin
               want = prev_sig + SAW_STEP;              // wraps in 12 bits
               expect_equal("sig_sample", 32'(sig_sample), 32'(want));
            end
         dds_lab_pkg::WAVE_SQUARE:
            expect_true(sig_sample == SQ_HIGH || sig_sample == SQ_LOW,
                        $sformatf("square sample %0d is not full scale", s));
         default:
            expect_true(s >= -SINE_PEAK && s <= SINE_PEAK,
                        $sformatf("sine sample %0d outside the table range", s));
      endcase
      if (cur_kind == dds_lab_pkg::WAVE_SIN)
      begin
         case (prev_mod_sel)
            dds_lab_pkg::MOD_OOK:    want = prev_lfsr[0] ? 12'sd0 : sig_sample;
            dds_lab_pkg::MOD_SQUARE: want = (s > 0) ? SQ_HIGH : SQ_LOW;   // same phase half
            dds_lab_pkg::MOD_NONE:   want = 12'sd0;
            default:                 want = prev_lfsr[0] ? SQ_HIGH : SQ_LOW;
         endcase
         expect_equal("mod_sample", 32'(mod_sample), 32'(want));
      end
      since_strobe++;
      if (scope_strobe)
      begin
         expect_equal("scope.sig_trace", 32'(scope.sig_trace), 32'(offset_binary(prev_sig)));
         expect_equal("scope.mod_trace", 32'(scope.mod_trace), 32'(offset_binary(prev_mod)));
         if (strobe_seen)
            expect_equal("scope_strobe spacing", 32'(since_strobe), 32'(SCOPE_DIVIDE));
         since_strobe = 0;
         strobe_seen  = 1'b1;
      end
   endtask

   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         settle      = 0;
         strobe_seen = 1'b0;
      end
      else if (settle < 3)
         settle++;
      cur_kind = prev_wave_sel;                         // mux saw last cycle's selection
      if (settle == 3)
         check_cycle();
      prev_kind     = cur_kind;
      prev_wave_sel = wave_sel;
      prev_mod_sel  = mod_sel;
      prev_lfsr     = lfsr_state;
      prev_sig      = sig_sample;
      prev_mod      = mod_sample;
   end

   //////////////////////////////
   // stimulus
   //////////////////////////////
   task automatic drive_sequence();
      int         pick;
      int         extra;
      logic [6:0] code;
      // random presses and releases with a stray code now and then
      for (int n = 0; n < 48; n++)
      begin
         random_bits(5, pick);
         pick = pick % NUM_KEYS;
         send_event(model_keys[model_pos(pick)], KEY_CODES[pick]);
         if (n % 3 == 2)
         begin
            random_bits(8, extra);
            code = 7'(extra);
            if (code_index(code) >= 0)
               code = 7'h00;
            send_event(extra[7], code);
         end
      end
      for (int i = 0; i < NUM_KEYS; i++)
         if (model_keys[model_pos(i)])
            send_event(1'b1, KEY_CODES[i]);
      for (int i = 8; i < NUM_KEYS; i++)
         press_key(i);                                  // every non-number key once

      press_key(3);                                     // saw
      wait_strobes(28);                                 // runs past a full 12-bit wrap
      if (timed_out)
         return;
      press_key(2);                                     // square
      wait_strobes(4);
      if (timed_out)
         return;
      press_key(1);                                     // cosine
      wait_strobes(2);
      if (timed_out)
         return;
      press_key(0);                                     // sine under every modulation
      for (int m = 4; m < 8; m++)
      begin
         press_key(m);
         wait_lfsr_steps(8);
         if (timed_out)
            return;
      end
      wait_strobes(2);
   endtask

   initial
   begin
      CLK_25MHZ       = 1'b0;
      reset_from_key  = 1'b1;
      key_event_valid = 1'b0;
      key_event       = '0;
      error_count     = 0;
      check_count     = 0;
      timed_out       = 1'b0;
      rand_state      = 32'h918c045a;
      model_keys      = '0;
      model_wave      = dds_lab_pkg::WAVE_SIN;
      model_mod       = dds_lab_pkg::MOD_OOK;
      settle          = 0;
      since_strobe    = 0;
      strobe_seen     = 1'b0;
      prev_lfsr       = 5'd1;
      prev_wave_sel   = dds_lab_pkg::WAVE_SIN;
      prev_mod_sel    = dds_lab_pkg::MOD_OOK;
      prev_kind       = dds_lab_pkg::WAVE_SIN;
      prev_sig        = '0;
      prev_mod        = '0;
      repeat (4) @(negedge CLK_25MHZ);
      reset_from_key = 1'b0;

      expect_equal("held_keys", 32'(held_keys), 32'd0);
      expect_equal("wave_sel", 32'(wave_sel), 32'(dds_lab_pkg::WAVE_SIN));
      expect_equal("mod_sel", 32'(mod_sel), 32'(dds_lab_pkg::MOD_OOK));
      expect_equal("lfsr_state", 32'(lfsr_state), 32'd1);
      expect_equal("scope_strobe", 32'(scope_strobe), 32'd0);

      drive_sequence();
      end_run();
   end

endmodule

//--- compile.f
+incdir+verilog
verilog/dds_lab_pkg.sv
verilog/keypad_control.sv
verilog/prbs_source.sv
verilog/dds_waveform_gen.sv
verilog/modulation_mux.sv
verilog/scope_sampler.sv
verilog/dds_lab_top.sv
test/tb_dds_lab.sv

//--- Makefile
# Verilator flow for the DDS lab core

VERILATOR  ?= verilator
FILE_LIST  := compile.f
TB_TOP     := tb_dds_lab
RTL_TOP    := dds_lab_top
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
SIM_LOG    := sim.log
PASS_TEXT  := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

$(OBJ_DIR)/V$(TB_TOP): $(FILE_LIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	grep -q '$(PASS_TEXT)' $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
